// File: source/msx_pkg.sv
package msx_pkg;

    // Widths that carry a meaning on the buses
    typedef logic [15:0] cpu_addr_t;    // Z80 address
    typedef logic [7:0]  byte_t;        // CPU / RAM data byte
    typedef logic [26:0] ram_addr_t;    // External RAM byte address
    typedef logic [15:0] blocks_t;      // Region size in 16 KB blocks
    typedef logic [5:0]  layout_id_t;   // {slot, subslot, page}
    typedef logic [3:0]  ram_ref_t;     // RAM lookup index

    // Mapper kinds kept in this core
    typedef enum logic [1:0] {
        map_none   = 2'd0,              // Nothing mapped so reads float high
        map_plain  = 2'd1,              // Linear ROM/RAM
        map_ascii8 = 2'd2               // Four 8 KB switchable banks
    } mapper_e;

    // APB slave phases
    typedef enum logic {
        apb_idle   = 1'b0,
        apb_access = 1'b1
    } apb_state_e;

    // Table depths
    localparam int LAYOUT_ENTRIES = 64;   // 4 slots x 4 subslots x 4 pages
    localparam int RAM_ENTRIES    = 16;

    // 16 KB page granularity
    localparam int BLOCK_SHIFT = 14;

    // ASCII8 works in 8 KB windows
    localparam int BANK_SHIFT = 13;
    localparam cpu_addr_t ASCII8_WIN_LO = 16'h4000;
    localparam cpu_addr_t ASCII8_WIN_HI = 16'hBFFF;

    // Expander register reads back inverted
    localparam cpu_addr_t SUBSLOT_REG_ADDR = 16'hFFFF;

    // APB map in byte addresses of 32-bit words
    localparam logic [11:0] LAYOUT_BASE   = 12'h000;   // 64 words
    localparam logic [11:0] RAM_BASE      = 12'h100;   // 16 x {base, size}
    localparam logic [11:0] EXPANDER_ADDR = 12'h180;

    // Layout word holds the mapper in [1:0] and the RAM reference from here up
    localparam int LAYOUT_REF_LSB = 4;

    // RAM size word carries blocks in [15:0] and the read-only flag here
    localparam int RAM_RO_BIT = 16;

endpackage

// File: source/msx_slot_cfg.sv
`timescale 1ns/100ps

module msx_slot_cfg import msx_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // APB configuration
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // Lookup side
    input  logic [1:0]  active_slot,
    input  logic [1:0]  active_subslot,
    input  cpu_addr_t   cpu_addr,
    output logic [3:0]  expander_en,      // Per primary slot
    output mapper_e     active_map,
    output ram_addr_t   active_base,
    output blocks_t     active_blocks,
    output logic        active_ro
);

    apb_state_e state;

    // Tables
    mapper_e   layout_map [LAYOUT_ENTRIES];
    ram_ref_t  layout_ref [LAYOUT_ENTRIES];
    ram_addr_t ram_base   [RAM_ENTRIES];
    blocks_t   ram_blocks [RAM_ENTRIES];
    logic      ram_ro     [RAM_ENTRIES];

    // Address decode
    logic       sel_layout, sel_ram, sel_exp, addr_ok;
    logic       access, wr_en;
    layout_id_t lay_idx;
    ram_ref_t   ram_idx;
    layout_id_t layout_id;
    ram_ref_t   act_ref;

    assign sel_layout = paddr[11:8] == LAYOUT_BASE[11:8];
    assign sel_ram    = paddr[11:7] == RAM_BASE[11:7];
    assign sel_exp    = paddr[11:2] == EXPANDER_ADDR[11:2];
    assign addr_ok    = sel_layout | sel_ram | sel_exp;
    assign lay_idx    = paddr[7:2];            // One word per entry
    assign ram_idx    = paddr[6:3];            // Two words per entry

    assign access  = (state == apb_access) & psel & penable;
    assign pready  = access;                   // No wait states
    assign pslverr = access & ~addr_ok;
    assign wr_en   = access & pwrite & addr_ok;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= apb_idle;
        end else begin
            case (state)
                apb_idle:   if (psel && !penable) state <= apb_access;  // Setup seen
                apb_access: if (penable || !psel) state <= apb_idle;
                default:    state <= apb_idle;
            endcase
        end
    end

    // Control part of the tables
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            expander_en <= '0;
            for (int i = 0; i < LAYOUT_ENTRIES; i++) layout_map[i] <= map_none;
        end else if (wr_en) begin
            if (sel_layout) layout_map[lay_idx] <= mapper_e'(pwdata[1:0]);
            if (sel_exp)    expander_en <= pwdata[3:0];
        end
    end

    // Layout references and RAM regions
    always_ff @(posedge clk) begin
        if (wr_en && sel_layout)
            layout_ref[lay_idx] <= pwdata[LAYOUT_REF_LSB +: $bits(ram_ref_t)];
        if (wr_en && sel_ram) begin
            if (!paddr[2]) begin
                ram_base[ram_idx] <= pwdata[26:0];    // Word 0 holds the base
            end else begin
                ram_blocks[ram_idx] <= pwdata[15:0];  // Word 1 holds size and ro flag
                ram_ro[ram_idx]     <= pwdata[RAM_RO_BIT];
            end
        end
    end

    // Readback mux
    always_comb begin
        prdata = '0;
        if (sel_layout) begin
            prdata[1:0] = layout_map[lay_idx];
            prdata[LAYOUT_REF_LSB +: $bits(ram_ref_t)] = layout_ref[lay_idx];
        end else if (sel_ram) begin
            if (!paddr[2]) begin
                prdata[26:0] = ram_base[ram_idx];
            end else begin
                prdata[15:0]       = ram_blocks[ram_idx];
                prdata[RAM_RO_BIT] = ram_ro[ram_idx];
            end
        end else if (sel_exp) begin
            prdata[3:0] = expander_en;
        end
    end

    // Layout entry chained into its RAM region
    assign layout_id     = {active_slot, active_subslot, cpu_addr[15:14]};
    assign act_ref       = layout_ref[layout_id];
    assign active_map    = layout_map[layout_id];
    assign active_base   = ram_base[act_ref];
    assign active_blocks = ram_blocks[act_ref];
    assign active_ro     = ram_ro[act_ref];

endmodule

// File: source/msx_subslot.sv
`timescale 1ns/100ps

module msx_subslot import msx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_addr_t  cpu_addr,
    input  byte_t      cpu_dout,        // Data from CPU
    input  logic       cpu_wr,          // One-cycle strobe
    input  logic       cpu_rd,          // Read level
    input  logic [1:0] active_slot,
    input  logic [3:0] expander_en,
    output logic [1:0] active_subslot,
    output byte_t      subslot_data,
    output logic       subslot_hit      // Expander owns the data bus
);

    // One register per primary slot, 2 bits per page
    byte_t subslot_reg [4];

    logic  expanded;
    logic  reg_addr;
    byte_t cur_reg;

    assign expanded = expander_en[active_slot];
    assign reg_addr = cpu_addr == SUBSLOT_REG_ADDR;
    assign cur_reg  = subslot_reg[active_slot];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) subslot_reg[i] <= '0;
        end else if (cpu_wr && reg_addr && expanded) begin
            subslot_reg[active_slot] <= cpu_dout;   // Plain slot ignores it
        end
    end

    // Subslot of the page being addressed
    always_comb begin
        case (cpu_addr[15:14])
            2'd0:    active_subslot = cur_reg[1:0];
            2'd1:    active_subslot = cur_reg[3:2];
            2'd2:    active_subslot = cur_reg[5:4];
            default: active_subslot = cur_reg[7:6];
        endcase
        if (!expanded)
            active_subslot = 2'd0;                  // Only subslot 0 exists
    end

    // Readback is inverted on real expanders
    assign subslot_data = ~cur_reg;
    assign subslot_hit  = cpu_rd & reg_addr & expanded;

endmodule

// File: source/msx_mapper.sv
`timescale 1ns/100ps

module msx_mapper import msx_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  cpu_addr_t  cpu_addr,
    input  byte_t      cpu_dout,
    input  logic       cpu_wr,
    input  mapper_e    active_map,
    input  logic [1:0] active_slot,
    output ram_addr_t  block_offset,    // Offset inside the RAM region
    output logic       map_valid
);

    // ASCII8 bank numbers, four per primary slot
    byte_t bank_reg [4][4];

    logic       bank_wr;
    logic       in_win;
    logic [1:0] win_idx;
    byte_t      bank_sel;

    // Bank registers sit at 6000h-7FFFh, 2 KB apart
    assign bank_wr = cpu_wr & (active_map == map_ascii8) & (cpu_addr[15:13] == 3'b011);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < 4; s++) begin
                for (int b = 0; b < 4; b++) bank_reg[s][b] <= '0;
            end
        end else if (bank_wr) begin
            bank_reg[active_slot][cpu_addr[12:11]] <= cpu_dout;
        end
    end

    // 4000h 6000h 8000h A000h map to windows 0..3
    assign in_win   = (cpu_addr >= ASCII8_WIN_LO) && (cpu_addr <= ASCII8_WIN_HI);
    assign win_idx  = {cpu_addr[15], cpu_addr[13]};
    assign bank_sel = bank_reg[active_slot][win_idx];

    always_comb begin
        block_offset = '0;
        map_valid    = 1'b0;
        case (active_map)
            map_plain: begin
                // Page number times 16 KB plus address in page
                block_offset = ram_addr_t'(cpu_addr[15:BLOCK_SHIFT]) << BLOCK_SHIFT;
                block_offset = block_offset | ram_addr_t'(cpu_addr[BLOCK_SHIFT-1:0]);
                map_valid    = 1'b1;
            end
            map_ascii8: begin
                // Bank times 8 KB plus low 13 bits
                block_offset = ram_addr_t'({bank_sel, cpu_addr[BANK_SHIFT-1:0]});
                map_valid    = in_win;                 // Outside window nothing
            end
            default: begin
                block_offset = '0;
                map_valid    = 1'b0;
            end
        endcase
    end

endmodule

// File: source/msx_mem_route.sv
`timescale 1ns/100ps

module msx_mem_route import msx_pkg::*; (
    input  cpu_addr_t cpu_addr,
    input  logic      cpu_wr,
    input  logic      cpu_rd,
    input  ram_addr_t active_base,
    input  blocks_t   active_blocks,
    input  logic      active_ro,
    input  ram_addr_t block_offset,
    input  logic      map_valid,
    input  logic      subslot_hit,
    input  byte_t     subslot_data,
    input  byte_t     ram_dout,         // Data from RAM
    output ram_addr_t ram_addr,
    output logic      ram_rnw,          // High = read
    output logic      sdram_ce,
    output byte_t     data,             // To CPU
    output logic      data_oe_rq
);

    // Region limit in bytes needs more bits than ram_addr_t
    logic [$bits(blocks_t)+BLOCK_SHIFT-1:0] limit;
    logic in_bounds;
    logic mapped;
    logic sub_reg;

    assign limit     = {active_blocks, {BLOCK_SHIFT{1'b0}}};
    assign in_bounds = {{($bits(limit)-$bits(ram_addr_t)){1'b0}}, block_offset} < limit;
    assign mapped    = map_valid & in_bounds;

    // FFFFh belongs to the expander and is never written through
    assign sub_reg = cpu_addr == SUBSLOT_REG_ADDR;

    assign ram_addr = active_base + block_offset;
    assign sdram_ce = mapped & ~subslot_hit & (cpu_rd | cpu_wr);
    assign ram_rnw  = ~cpu_wr | active_ro | sub_reg;   // ROM stays read

    // Expander readback has priority and empty space floats high
    always_comb begin
        if (subslot_hit)
            data = subslot_data;
        else if (mapped)
            data = ram_dout;
        else
            data = 8'hFF;
    end

    assign data_oe_rq = subslot_hit;

endmodule

// File: source/msx_slots.sv
`timescale 1ns/100ps

module msx_slots import msx_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // APB configuration
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    // CPU strobe bus
    input  cpu_addr_t   cpu_addr,
    input  byte_t       cpu_dout,
    input  logic        cpu_wr,
    input  logic        cpu_rd,
    input  logic [1:0]  active_slot,    // From the PPI
    // External RAM
    output ram_addr_t   ram_addr,
    output logic        ram_rnw,
    output logic        sdram_ce,
    input  byte_t       ram_dout,
    // Back to CPU
    output byte_t       data,
    output logic        data_oe_rq
);

    logic [3:0] expander_en;
    logic [1:0] active_subslot;
    byte_t      subslot_data;
    logic       subslot_hit;
    mapper_e    active_map;
    ram_addr_t  active_base;
    blocks_t    active_blocks;
    logic       active_ro;
    ram_addr_t  block_offset;
    logic       map_valid;

    // Tables and region lookup
    msx_slot_cfg u_cfg (
        .clk, .rst_n,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr,
        .active_slot, .active_subslot, .cpu_addr,
        .expander_en, .active_map, .active_base, .active_blocks, .active_ro
    );

    // FFFFh expander registers
    msx_subslot u_subslot (
        .clk, .rst_n, .cpu_addr, .cpu_dout, .cpu_wr, .cpu_rd,
        .active_slot, .expander_en, .active_subslot, .subslot_data, .subslot_hit
    );

    // Offset inside the region
    msx_mapper u_mapper (
        .clk, .rst_n, .cpu_addr, .cpu_dout, .cpu_wr,
        .active_map, .active_slot, .block_offset, .map_valid
    );

    // RAM side and data return
    msx_mem_route u_route (
        .cpu_addr, .cpu_wr, .cpu_rd,
        .active_base, .active_blocks, .active_ro, .block_offset, .map_valid,
        .subslot_hit, .subslot_data, .ram_dout,
        .ram_addr, .ram_rnw, .sdram_ce, .data, .data_oe_rq
    );

endmodule

// File: verif/msx_slots_chk.sv
`timescale 1ns/100ps

module msx_slots_chk import msx_pkg::*; (
    input logic        clk,
    input logic        rst_n,
    input logic        psel,
    input logic        penable,
    input logic [11:0] paddr,
    input logic        pready,
    input logic        pslverr,
    input cpu_addr_t   cpu_addr,
    input logic        cpu_wr,
    input mapper_e     active_map,
    input ram_addr_t   active_base,
    input logic        active_ro,
    input ram_addr_t   ram_addr,
    input logic        ram_rnw,
    input logic        sdram_ce
);

    localparam logic [11:0] MAP_END = EXPANDER_ADDR + 12'h004;  // First word past the map

    int fail_cnt = 0;   // Failed assertions so far

    // Setup phase followed by access phase, slave answers at once
    a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n)
        (psel && !penable) ##1 (psel && penable) |-> pready)
        else begin
            $error("pready missing in the APB access cycle");
            fail_cnt++;
        end

    // Never early, never outside an access
    a_ready_only_access: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> psel && penable && $past(psel) && !$past(penable))
        else begin
            $error("pready outside the APB access cycle");
            fail_cnt++;
        end

    // Error exactly for holes in the map
    a_err_decode: assert property (@(posedge clk) disable iff (!rst_n)
        pready |-> (pslverr == (paddr >= MAP_END)))
        else begin
            $error("pslverr does not match the APB address map at %h", paddr);
            fail_cnt++;
        end

    // Plain region is linear, offset is the CPU address itself
    a_plain_addr: assert property (@(posedge clk) disable iff (!rst_n)
        (sdram_ce && active_map == map_plain) |-> ram_addr == active_base + ram_addr_t'(cpu_addr))
        else begin
            $error("plain routing sent %h to RAM", ram_addr);
            fail_cnt++;
        end

    // ROM must stay a read even on a CPU write
    a_ro_write: assert property (@(posedge clk) disable iff (!rst_n)
        (cpu_wr && active_ro) |-> ram_rnw)
        else begin
            $error("write reached a read-only region");
            fail_cnt++;
        end

    // Empty layout entries never select RAM
    a_none_no_ce: assert property (@(posedge clk) disable iff (!rst_n)
        (active_map == map_none) |-> !sdram_ce)
        else begin
            $error("sdram_ce raised for an unmapped page");
            fail_cnt++;
        end

endmodule

bind msx_slots msx_slots_chk chk0 (.*);

// File: verif/tb_msx_slots.sv
`timescale 1ns/100ps

module tb_msx_slots import msx_pkg::*; ();

    localparam int TIMEOUT = 20;        // Cycles per wait

    logic        clk;
    logic        rst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    cpu_addr_t   cpu_addr;
    byte_t       cpu_dout;
    logic        cpu_wr;
    logic        cpu_rd;
    logic [1:0]  active_slot;
    ram_addr_t   ram_addr;
    logic        ram_rnw;
    logic        sdram_ce;
    byte_t       ram_dout;
    byte_t       data;
    logic        data_oe_rq;

    int          seed = 38618;
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;
    logic [31:0] rd_data;              // Last APB result
    logic        rd_err;
    logic        oe_seen;              // data_oe_rq of the last CPU access
    byte_t       banks [4] = '{default: 8'h00};  // ASCII8 model of slot 1
    cpu_addr_t   addr16;
    ram_addr_t   exp_addr;
    logic [11:0] cfg_addr [13];
    logic [31:0] cfg_data [13];

    msx_slots dut0 (.*);

    // RAM contents, folded from every address bit
    function automatic byte_t ram_pattern(input ram_addr_t a);
        return a[7:0] ^ a[15:8] ^ a[23:16] ^ {5'd0, a[26:24]} ^ 8'hA5;
    endfunction

    assign ram_dout = ram_pattern(ram_addr);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        checks++;
        assert (act === exp)
        else begin
            errors++;
            $display("Mismatch %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic apb_transfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata);
        int cnt;
        @(posedge clk);
        #1;
        psel    = 1'b1;                 // Setup phase
        penable = 1'b0;
        pwrite  = wr;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk);
        #1;
        penable = 1'b1;                 // Access phase
        cnt = 0;
        @(negedge clk);
        while (!pready && cnt < TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!pready) begin
            timeouts++;
            $display("APB access at %h never got pready", addr);
        end
        rd_data = prdata;
        rd_err  = pslverr;
        @(posedge clk);                 // Write lands here
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] wdata);
        apb_transfer(1'b1, addr, wdata);
    endtask

    task automatic apb_read(input string name, input logic [11:0] addr, input logic [31:0] exp);
        apb_transfer(1'b0, addr, 32'h0);
        compare_value(name, exp, rd_data);
    endtask

    // One CPU cycle, routing outputs sampled mid-cycle
    task automatic cpu_access(input string name, input cpu_addr_t addr, input logic wr,
                              input byte_t wdata, input logic exp_ce, input ram_addr_t exp_ram,
                              input logic exp_rnw, input byte_t exp_data);
        @(posedge clk);
        #1;
        cpu_addr = addr;
        cpu_dout = wdata;
        cpu_wr   = wr;
        cpu_rd   = ~wr;
        @(negedge clk);
        compare_value({name, " ce"}, exp_ce, sdram_ce);
        if (exp_ce)
            compare_value({name, " addr"}, exp_ram, ram_addr);
        compare_value({name, " rnw"}, exp_rnw, ram_rnw);
        if (!wr)
            compare_value({name, " data"}, exp_data, data);
        oe_seen = data_oe_rq;
        @(posedge clk);                 // Strobe ends, registers update
        #1;
        cpu_wr = 1'b0;
        cpu_rd = 1'b0;
    endtask

    initial begin
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = '0;
        pwdata      = '0;
        cpu_addr    = '0;
        cpu_dout    = '0;
        cpu_wr      = 1'b0;
        cpu_rd      = 1'b0;
        active_slot = 2'd0;
        // RAM regions 0..2, then layout words {slot, subslot, page}, then expanders
        cfg_addr = '{12'h100, 12'h104, 12'h108, 12'h10C, 12'h110, 12'h114,
                     12'h000, 12'h004, 12'h008, 12'h05C, 12'h064, 12'h068, 12'h180};
        cfg_data = '{32'h0100000, 32'h00002, 32'h0200000, 32'h10004, 32'h0400000, 32'h00080,
                     32'h01, 32'h01, 32'h01, 32'h11, 32'h22, 32'h22, 32'h2};
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        compare_value("reset_outputs", 5'b00001, {pready, pslverr, sdram_ce, data_oe_rq, ram_rnw});

        foreach (cfg_addr[i]) apb_write(cfg_addr[i], cfg_data[i]);
        foreach (cfg_addr[i]) apb_read("apb_readback", cfg_addr[i], cfg_data[i]);
        apb_transfer(1'b1, 12'h184, 32'hF);        // Hole right after the expander word
        compare_value("apb_err_write", 1'b1, rd_err);
        apb_transfer(1'b0, 12'h200, 32'h0);
        compare_value("apb_err_read", 1'b1, rd_err);
        apb_read("apb_no_side_effect", 12'h180, 32'h2);

        // Slot 1 expanded, pages 1 and 2 in subslot 2, page 3 in subslot 1
        active_slot = 2'd1;
        cpu_access("subslot_wr", 16'hFFFF, 1'b1, 8'h68, 1'b0, '0, 1'b1, 8'h00);
        cpu_access("subslot_rd", 16'hFFFF, 1'b0, 8'h00, 1'b0, '0, 1'b1, 8'h97);
        compare_value("subslot_oe", 1'b1, oe_seen);
        active_slot = 2'd0;                         // Not expanded, write is ignored
        cpu_access("plain_slot_wr", 16'hFFFF, 1'b1, 8'h55, 1'b0, '0, 1'b1, 8'h00);
        apb_write(12'h180, 32'h3);
        cpu_access("plain_slot_rd", 16'hFFFF, 1'b0, 8'h00, 1'b0, '0, 1'b1, 8'hFF);
        compare_value("plain_slot_oe", 1'b1, oe_seen);
        apb_write(12'h180, 32'h2);

        // Plain region of 32 KB at 100000h
        cpu_access("plain_rd", 16'h1234, 1'b0, 8'h00, 1'b1, 27'h0101234, 1'b1,
                   ram_pattern(27'h0101234));
        cpu_access("plain_wr", 16'h2000, 1'b1, 8'h3C, 1'b1, 27'h0102000, 1'b0, 8'h00);
        repeat (4) begin
            addr16   = 16'($random(seed)) & 16'h7FFF;
            exp_addr = 27'h0100000 + ram_addr_t'(addr16);
            cpu_access("plain_rand_rd", addr16, 1'b0, 8'h00, 1'b1, exp_addr, 1'b1,
                       ram_pattern(exp_addr));
        end
        cpu_access("plain_out_of_bounds", 16'h9000, 1'b0, 8'h00, 1'b0, '0, 1'b1, 8'hFF);

        // ASCII8 in slot 1 subslot 2, region at 400000h
        active_slot = 2'd1;
        for (int b = 0; b < 4; b++) begin
            addr16   = 16'h6000 + 16'(b) * 16'h0800;
            exp_addr = 27'h0400000 + ram_addr_t'(banks[1]) * 27'h2000 + ram_addr_t'(addr16[12:0]);
            banks[b] = byte_t'($random(seed));
            cpu_access("ascii8_bank_wr", addr16, 1'b1, banks[b], 1'b1, exp_addr, 1'b0, 8'h00);
        end
        for (int b = 0; b < 4; b++) begin
            addr16   = 16'h4000 + 16'(b) * 16'h2000 + (16'($random(seed)) & 16'h1FFF);
            exp_addr = 27'h0400000 + ram_addr_t'(banks[b]) * 27'h2000 + ram_addr_t'(addr16[12:0]);
            cpu_access("ascii8_rd", addr16, 1'b0, 8'h00, 1'b1, exp_addr, 1'b1,
                       ram_pattern(exp_addr));
        end

        // Read-only region of 64 KB at 200000h, page 3 of subslot 1
        cpu_access("ro_wr", 16'hC100, 1'b1, 8'hAA, 1'b1, 27'h020C100, 1'b1, 8'h00);
        cpu_access("ro_rd", 16'hC100, 1'b0, 8'h00, 1'b1, 27'h020C100, 1'b1,
                   ram_pattern(27'h020C100));

        // Slot 3 has no layout entries
        active_slot = 2'd3;
        cpu_access("unmapped_rd_lo", 16'h4000, 1'b0, 8'h00, 1'b0, '0, 1'b1, 8'hFF);
        cpu_access("unmapped_rd_hi", 16'hC000, 1'b0, 8'h00, 1'b0, '0, 1'b1, 8'hFF);

        repeat (2) @(posedge clk);
        $display("Checks %0d, mismatches %0d, timeouts %0d, assertion failures %0d",
                 checks, errors, timeouts, dut0.chk0.fail_cnt);
        if (errors + timeouts + dut0.chk0.fail_cnt == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// File: compile.f
source/msx_pkg.sv
source/msx_slot_cfg.sv
source/msx_subslot.sv
source/msx_mapper.sv
source/msx_mem_route.sv
source/msx_slots.sv
verif/msx_slots_chk.sv
verif/tb_msx_slots.sv
